// ==== vlog.f ====
+incdir+include
+incdir+tests
source/mfp_ahb_pkg.sv
source/mfp_ahb_decoder.sv
source/mfp_ahb_ram.sv
source/mfp_ahb_gpio.sv
source/mfp_ahb_uart.sv
source/mfp_ahb_lite_matrix.sv
tests/tb_mfp_ahb_lite_matrix.sv

// ==== Makefile ====
TOP = tb_mfp_ahb_lite_matrix

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -qx "No errors" sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module mfp_ahb_lite_matrix

clean:
	rm -rf obj_dir sim.log

// ==== tests/tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef enum logic [3:0] {
    op_write,
    op_write_rand,
    op_read,
    op_read_model,
    op_inputs_rand,
    op_check_leds,
    op_uart_write,
    op_uart_stall,
    op_uart_wait
} op_t;

typedef struct packed {
    op_t         op;
    logic [31:0] addr;
    logic [2:0]  size;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        resp;
} vector_t;

localparam int num_vectors = 33;

// op, address, size, write data, expected read data, expected hresp
localparam vector_t vectors [num_vectors] = '{
    '{op_write,       32'h0000_0000, hsize_word, 32'h1234_5678, 32'h0000_0000, 1'b0},
    '{op_read,        32'h0000_0000, hsize_word, 32'h0000_0000, 32'h1234_5678, 1'b0},
    '{op_write_rand,  32'h0000_0004, hsize_word, 32'h0000_0000, 32'h0000_0000, 1'b0},
    '{op_write_rand,  32'h0000_0FFC, hsize_word, 32'h0000_0000, 32'h0000_0000, 1'b0},
    '{op_read_model,  32'h0000_0004, hsize_word, 32'h0000_0000, 32'h0000_0000, 1'b0},
    '{op_read_model,  32'h0000_0FFC, hsize_word, 32'h0000_0000, 32'h0000_0000, 1'b0},
    // partial writes over words written above
    '{op_write,       32'h0000_0001, hsize_byte, 32'h0000_AB00, 32'h0000_0000, 1'b0},
    '{op_read_model,  32'h0000_0000, hsize_word, 32'h0000_0000, 32'h0000_0000, 1'b0},
    '{op_write,       32'h0000_0006, hsize_half, 32'hBEEF_0000, 32'h0000_0000, 1'b0},
    '{op_read_model,  32'h0000_0004, hsize_word, 32'h0000_0000, 32'h0000_0000, 1'b0},
    '{op_write,       32'h0000_0003, hsize_byte, 32'hC300_0000, 32'h0000_0000, 1'b0},
    '{op_read_model,  32'h0000_0002, hsize_half, 32'h0000_0000, 32'h0000_0000, 1'b0},
    // gpio
    '{op_write,       32'h1F80_0000, hsize_word, 32'hFFFF_FFFF, 32'h0000_0000, 1'b0},
    '{op_write,       32'h1F80_0004, hsize_word, 32'h0000_0ABC, 32'h0000_0000, 1'b0},
    '{op_check_leds,  32'h0000_0000, hsize_word, 32'h0000_0000, 32'h0000_0000, 1'b0},
    '{op_read_model,  32'h1F80_0000, hsize_word, 32'h0000_0000, 32'h0000_0000, 1'b0},
    '{op_read_model,  32'h1F80_0004, hsize_word, 32'h0000_0000, 32'h0000_0000, 1'b0},
    '{op_inputs_rand, 32'h0000_0000, hsize_word, 32'h0000_0000, 32'h0000_0000, 1'b0},
    '{op_read_model,  32'h1F80_0008, hsize_word, 32'h0000_0000, 32'h0000_0000, 1'b0},
    '{op_read_model,  32'h1F80_000C, hsize_word, 32'h0000_0000, 32'h0000_0000, 1'b0},
    '{op_write,       32'h1F80_0008, hsize_word, 32'hFFFF_FFFF, 32'h0000_0000, 1'b0},
    '{op_read_model,  32'h1F80_0008, hsize_word, 32'h0000_0000, 32'h0000_0000, 1'b0},
    // uart, one frame then a stalled pair
    '{op_uart_write,  32'h1F90_0000, hsize_word, 32'h0000_005A, 32'h0000_0000, 1'b0},
    '{op_read,        32'h1F90_0004, hsize_word, 32'h0000_0000, 32'h0000_0001, 1'b0},
    '{op_uart_wait,   32'h0000_0000, hsize_word, 32'h0000_0000, 32'h0000_0000, 1'b0},
    '{op_read,        32'h1F90_0004, hsize_word, 32'h0000_0000, 32'h0000_0000, 1'b0},
    '{op_uart_write,  32'h1F90_0000, hsize_word, 32'h0000_00A5, 32'h0000_0000, 1'b0},
    '{op_uart_stall,  32'h1F90_0000, hsize_word, 32'h0000_003C, 32'h0000_0000, 1'b0},
    '{op_uart_wait,   32'h0000_0000, hsize_word, 32'h0000_0000, 32'h0000_0000, 1'b0},
    // unmapped accesses
    '{op_read,        32'h4000_0000, hsize_word, 32'h0000_0000, 32'h0000_0000, 1'b1},
    '{op_read_model,  32'h0000_0000, hsize_word, 32'h0000_0000, 32'h0000_0000, 1'b0},
    '{op_write,       32'h4000_0010, hsize_word, 32'h5555_AAAA, 32'h0000_0000, 1'b1},
    '{op_read_model,  32'h0000_0FFC, hsize_word, 32'h0000_0000, 32'h0000_0000, 1'b0}
};

`endif

// ==== tests/tb_mfp_ahb_lite_matrix.sv ====
module tb_mfp_ahb_lite_matrix import mfp_ahb_pkg::*; ;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clks_per_bit   = 8;
    localparam int ram_addr_width = 10;
    localparam int seed           = 13824;

`include "tb_vectors.svh"

    localparam int timeout_cycles = num_vectors * (10 * clks_per_bit + 10) + 200;

    logic        hclk;
    logic        rst_n;
    logic [31:0] haddr;
    logic [2:0]  hsize;
    logic [1:0]  htrans;
    logic        hwrite;
    logic [31:0] hwdata;
    logic [31:0] hrdata;
    logic        hready;
    logic        hresp;
    logic [17:0] io_switches;
    logic [4:0]  io_buttons;
    logic [17:0] io_red_leds;
    logic [8:0]  io_green_leds;
    logic        uart_tx;

    int errors      = 0;
    int checks      = 0;
    int cycle_count = 0;

    // reference state of the peripherals
    logic [31:0] ram_model [int];
    logic [17:0] model_red      = '0;
    logic [8:0]  model_green    = '0;
    logic [17:0] model_switches = '0;
    logic [4:0]  model_buttons  = '0;
    logic [7:0]  uart_expected [$];
    logic [7:0]  rx_bytes [$];

    mfp_ahb_lite_matrix #(
        .ram_addr_width ( ram_addr_width ),
        .clks_per_bit   ( clks_per_bit   )
    ) dut_i (
        .hclk          ( hclk          ),
        .rst_n         ( rst_n         ),
        .haddr         ( haddr         ),
        .hsize         ( hsize         ),
        .htrans        ( htrans        ),
        .hwrite        ( hwrite        ),
        .hwdata        ( hwdata        ),
        .hrdata        ( hrdata        ),
        .hready        ( hready        ),
        .hresp         ( hresp         ),
        .io_switches   ( io_switches   ),
        .io_buttons    ( io_buttons    ),
        .io_red_leds   ( io_red_leds   ),
        .io_green_leds ( io_green_leds ),
        .uart_tx       ( uart_tx       )
    );

    initial begin
        hclk = 1'b0;
        forever #50 hclk = ~hclk;
    end

    always @(posedge hclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: run still going after %0d cycles", timeout_cycles);
            $display("Errors found");
            $finish;
        end
    end

    task automatic expect_value(input logic [31:0] actual, input logic [31:0] expected,
                                input string what);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Fail at %0d ns: %s got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic expect_true(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("Fail at %0d ns: %s", $time, what);
        end
    endtask

    // little-endian lanes touched by an access
    function automatic logic [31:0] lane_mask(input logic [31:0] addr, input logic [2:0] size);
        case (size)
            hsize_byte: return 32'h0000_00FF << (8 * addr[1:0]);
            hsize_half: return addr[1] ? 32'hFFFF_0000 : 32'h0000_FFFF;
            default:    return 32'hFFFF_FFFF;
        endcase
    endfunction

    function automatic logic in_ram(input logic [31:0] addr);
        return (addr & ram_region_mask) == ram_base;
    endfunction

    function automatic logic in_gpio(input logic [31:0] addr);
        return (addr & gpio_region_mask) == gpio_base;
    endfunction

    task automatic model_write(input logic [31:0] addr, input logic [2:0] size,
                               input logic [31:0] wdata);
        int          idx;
        logic [31:0] mask;
        logic [31:0] old;
        idx  = int'(addr[ram_addr_width+1:2]);
        mask = lane_mask(addr, size);
        if (in_ram(addr)) begin
            old = ram_model.exists(idx) ? ram_model[idx] : 32'h0;
            ram_model[idx] = (old & ~mask) | (wdata & mask);
        end else if (in_gpio(addr) && addr[3:0] == gpio_red_leds_off) begin
            model_red = wdata[17:0];
        end else if (in_gpio(addr) && addr[3:0] == gpio_green_leds_off) begin
            model_green = wdata[8:0];
        end
    endtask

    function automatic logic [31:0] model_read(input logic [31:0] addr);
        int idx;
        idx = int'(addr[ram_addr_width+1:2]);
        if (in_ram(addr))
            return ram_model.exists(idx) ? ram_model[idx] : 32'h0;
        if (!in_gpio(addr))
            return 32'h0;
        case (addr[3:0])
            gpio_red_leds_off:   return {14'b0, model_red};
            gpio_green_leds_off: return {23'b0, model_green};
            gpio_switches_off:   return {14'b0, model_switches};
            gpio_buttons_off:    return {27'b0, model_buttons};
            default:             return 32'h0;
        endcase
    endfunction

    // one single transfer through its address and data phase
    task automatic bus_transfer(input logic write, input logic [31:0] addr,
                                input logic [2:0] size, input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic resp,
                                output int wait_cycles, output logic err_first);
        @(negedge hclk);
        haddr  = addr;
        hwrite = write;
        hsize  = size;
        htrans = htrans_nonseq;
        while (!hready)
            @(negedge hclk);
        @(negedge hclk);
        htrans      = htrans_idle;
        hwdata      = wdata;
        wait_cycles = 0;
        err_first   = 1'b0;
        while (!hready) begin
            if (wait_cycles == 0)
                err_first = hresp;
            wait_cycles++;
            @(negedge hclk);
        end
        rdata = hrdata;
        resp  = hresp;
    endtask

    task automatic check_response(input vector_t v, input logic resp, input int wait_cycles,
                                  input logic err_first);
        if (v.resp)
            expect_true(wait_cycles == 1 && err_first,
                        $sformatf("error response at %h is not two cycles long", v.addr));
        else if (v.op == op_uart_stall)
            expect_true(wait_cycles > 0, "second uart write was not stalled");
        else
            expect_true(wait_cycles == 0, $sformatf("unexpected wait states at %h", v.addr));
        expect_value({31'b0, resp}, {31'b0, v.resp}, $sformatf("hresp at %h", v.addr));
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        @(negedge hclk);
        r              = $urandom;
        io_switches    = r[17:0];
        r              = $urandom;
        io_buttons     = r[4:0];
        model_switches = io_switches;
        model_buttons  = io_buttons;
        // let the input register stage catch up
        repeat (2) @(negedge hclk);
    endtask

    task automatic check_leds();
        @(negedge hclk);
        expect_value({14'b0, io_red_leds}, {14'b0, model_red}, "io_red_leds");
        expect_value({23'b0, io_green_leds}, {23'b0, model_green}, "io_green_leds");
    endtask

    task automatic wait_uart_bytes();
        int         limit;
        int         count;
        logic [7:0] expected;
        limit = uart_expected.size() * 12 * clks_per_bit;
        count = 0;
        while (rx_bytes.size() < uart_expected.size() && count < limit) begin
            @(negedge hclk);
            count++;
        end
        while (uart_expected.size() > 0) begin
            expected = uart_expected.pop_front();
            checks++;
            assert (rx_bytes.size() > 0) else begin
                errors++;
                $display("UART frame for byte %h never started", expected);
            end
            if (rx_bytes.size() > 0)
                expect_value({24'b0, rx_bytes.pop_front()}, {24'b0, expected}, "uart byte");
        end
        // stop bit still on the line
        repeat (clks_per_bit) @(negedge hclk);
    endtask

    task automatic run_vector(input vector_t v);
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [31:0] mask;
        logic        resp;
        int          wait_cycles;
        logic        err_first;
        wdata = v.wdata;
        mask  = lane_mask(v.addr, v.size);
        case (v.op)
            op_write, op_write_rand, op_uart_write, op_uart_stall: begin
                if (v.op == op_write_rand)
                    wdata = $urandom;
                bus_transfer(1'b1, v.addr, v.size, wdata, rdata, resp, wait_cycles, err_first);
                check_response(v, resp, wait_cycles, err_first);
                if (v.op == op_uart_write || v.op == op_uart_stall)
                    uart_expected.push_back(wdata[7:0]);
                else if (!v.resp)
                    model_write(v.addr, v.size, wdata);
            end
            op_read, op_read_model: begin
                bus_transfer(1'b0, v.addr, v.size, 32'h0, rdata, resp, wait_cycles, err_first);
                check_response(v, resp, wait_cycles, err_first);
                if (!v.resp && v.op == op_read)
                    expect_value(rdata & mask, v.rdata & mask, $sformatf("read %h", v.addr));
                else if (!v.resp)
                    expect_value(rdata & mask, model_read(v.addr) & mask,
                                 $sformatf("read %h", v.addr));
            end
            op_inputs_rand: drive_inputs();
            op_check_leds:  check_leds();
            op_uart_wait:   wait_uart_bytes();
            default: ;
        endcase
    endtask

    // samples each bit near its middle
    initial begin : uart_monitor
        logic [7:0] data;
        logic       start_bit;
        logic       stop_bit;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge uart_tx);
            repeat (clks_per_bit / 2) @(negedge hclk);
            start_bit = uart_tx;
            for (int i = 0; i < 8; i++) begin
                repeat (clks_per_bit) @(negedge hclk);
                data[i] = uart_tx;
            end
            repeat (clks_per_bit) @(negedge hclk);
            stop_bit = uart_tx;
            expect_true(start_bit == 1'b0, "uart start bit not low at its middle");
            expect_true(stop_bit == 1'b1, "uart stop bit not high");
            rx_bytes.push_back(data);
        end
    end

    initial begin : stimulus
        void'($urandom(seed));
        rst_n       = 1'b0;
        haddr       = '0;
        hsize       = hsize_word;
        htrans      = htrans_idle;
        hwrite      = 1'b0;
        hwdata      = '0;
        io_switches = '0;
        io_buttons  = '0;
        repeat (10) @(negedge hclk);
        rst_n = 1'b1;

        expect_value({31'b0, hready}, 32'h1, "hready after reset");
        expect_value({31'b0, hresp}, 32'h0, "hresp after reset");
        expect_value({14'b0, io_red_leds}, 32'h0, "io_red_leds after reset");
        expect_value({23'b0, io_green_leds}, 32'h0, "io_green_leds after reset");
        expect_value({31'b0, uart_tx}, 32'h1, "uart_tx after reset");

        for (int i = 0; i < num_vectors; i++)
            run_vector(vectors[i]);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== source/mfp_ahb_lite_matrix.sv ====
module mfp_ahb_lite_matrix import mfp_ahb_pkg::*; #(
    parameter int ram_addr_width = 10,
    parameter int clks_per_bit   = 434
) (
    input  logic        hclk,
    input  logic        rst_n,
    input  logic [31:0] haddr,
    input  logic [2:0]  hsize,
    input  logic [1:0]  htrans,
    input  logic        hwrite,
    input  logic [31:0] hwdata,
    output logic [31:0] hrdata,
    output logic        hready,
    output logic        hresp,
    input  logic [17:0] io_switches,
    input  logic [4:0]  io_buttons,
    output logic [17:0] io_red_leds,
    output logic [8:0]  io_green_leds,
    output logic        uart_tx
);

    ahb_req_t req;
    ahb_rsp_t ram_rsp;
    ahb_rsp_t gpio_rsp;
    ahb_rsp_t uart_rsp;
    logic     hsel_ram;
    logic     hsel_gpio;
    logic     hsel_uart;

    assign req = '{haddr: haddr, hwrite: hwrite, hsize: hsize, htrans: htrans, hwdata: hwdata};

    mfp_ahb_decoder decoder (
        .hclk      ( hclk      ),
        .rst_n     ( rst_n     ),
        .req       ( req       ),
        .hsel_ram  ( hsel_ram  ),
        .hsel_gpio ( hsel_gpio ),
        .hsel_uart ( hsel_uart ),
        .ram_rsp   ( ram_rsp   ),
        .gpio_rsp  ( gpio_rsp  ),
        .uart_rsp  ( uart_rsp  ),
        .hrdata    ( hrdata    ),
        .hready    ( hready    ),
        .hresp     ( hresp     )
    );

    mfp_ahb_ram #(.ram_addr_width(ram_addr_width)) ram (
        .hclk   ( hclk     ),
        .rst_n  ( rst_n    ),
        .req    ( req      ),
        .hsel   ( hsel_ram ),
        .hready ( hready   ),
        .rsp    ( ram_rsp  )
    );

    mfp_ahb_gpio gpio (
        .hclk       ( hclk          ),
        .rst_n      ( rst_n         ),
        .req        ( req           ),
        .hsel       ( hsel_gpio     ),
        .hready     ( hready        ),
        .rsp        ( gpio_rsp      ),
        .switches   ( io_switches   ),
        .buttons    ( io_buttons    ),
        .red_leds   ( io_red_leds   ),
        .green_leds ( io_green_leds )
    );

    mfp_ahb_uart #(.clks_per_bit(clks_per_bit)) uart (
        .hclk   ( hclk      ),
        .rst_n  ( rst_n     ),
        .req    ( req       ),
        .hsel   ( hsel_uart ),
        .hready ( hready    ),
        .rsp    ( uart_rsp  ),
        .tx     ( uart_tx   )
    );

endmodule

// ==== source/mfp_ahb_uart.sv ====
module mfp_ahb_uart import mfp_ahb_pkg::*; #(
    parameter int clks_per_bit = 434
) (
    input  logic     hclk,
    input  logic     rst_n,
    input  ahb_req_t req,
    input  logic     hsel,
    input  logic     hready,
    output ahb_rsp_t rsp,
    output logic     tx
);

    localparam int baud_w = $clog2(clks_per_bit + 1);

    logic [3:0]        reg_off;
    logic              data_pend;
    logic              busy;
    logic              load;
    logic              baud_tick;
    logic [9:0]        shift_q;
    logic [3:0]        bit_cnt;
    logic [baud_w-1:0] baud_cnt;

    always_ff @(posedge hclk) begin
        if (hready && hsel)
            reg_off <= req.haddr[3:0];
    end

    // transmit data write sitting in its data phase
    always_ff @(posedge hclk) begin
        if (!rst_n)
            data_pend <= 1'b0;
        else if (hready)
            data_pend <= hsel && ahb_active(req.htrans) && req.hwrite
                         && req.haddr[3:0] == uart_txdata_off;
    end

    assign load      = data_pend && !busy;
    assign baud_tick = baud_cnt == baud_w'(clks_per_bit - 1);

    // frame is stop, 8 data bits, start; shifted out from bit 0
    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            shift_q  <= '1;
            bit_cnt  <= '0;
            baud_cnt <= '0;
        end else if (load) begin
            busy     <= 1'b1;
            shift_q  <= {1'b1, req.hwdata[7:0], 1'b0};
            bit_cnt  <= '0;
            baud_cnt <= '0;
        end else if (busy) begin
            if (baud_tick) begin
                baud_cnt <= '0;
                shift_q  <= {1'b1, shift_q[9:1]};
                if (bit_cnt == 4'd9)
                    busy <= 1'b0;
                else
                    bit_cnt <= bit_cnt + 4'd1;
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    // line idles high once all ten bits are out
    assign tx = shift_q[0];

    assign rsp.hrdata = (reg_off == uart_status_off) ? {31'b0, busy} : '0;
    // stall a new byte until the current frame is done
    assign rsp.hready = !(data_pend && busy);
    assign rsp.hresp  = 1'b0;

endmodule

// ==== source/mfp_ahb_gpio.sv ====
module mfp_ahb_gpio import mfp_ahb_pkg::*; (
    input  logic        hclk,
    input  logic        rst_n,
    input  ahb_req_t    req,
    input  logic        hsel,
    input  logic        hready,
    output ahb_rsp_t    rsp,
    input  logic [17:0] switches,
    input  logic [4:0]  buttons,
    output logic [17:0] red_leds,
    output logic [8:0]  green_leds
);

    logic [3:0]  reg_off;
    logic        write_pend;
    logic [17:0] switches_q;
    logic [4:0]  buttons_q;

    always_ff @(posedge hclk) begin
        if (hready && hsel)
            reg_off <= req.haddr[3:0];
    end

    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            write_pend <= 1'b0;
            red_leds   <= '0;
            green_leds <= '0;
        end else begin
            if (write_pend && hready) begin
                case (reg_off)
                    gpio_red_leds_off:   red_leds   <= req.hwdata[17:0];
                    gpio_green_leds_off: green_leds <= req.hwdata[8:0];
                    default: ;
                endcase
            end
            if (hready)
                write_pend <= hsel && ahb_active(req.htrans) && req.hwrite;
        end
    end

    // one register stage on the pins
    always_ff @(posedge hclk) begin
        switches_q <= switches;
        buttons_q  <= buttons;
    end

    always_comb begin
        case (reg_off)
            gpio_red_leds_off:   rsp.hrdata = {14'b0, red_leds};
            gpio_green_leds_off: rsp.hrdata = {23'b0, green_leds};
            gpio_switches_off:   rsp.hrdata = {14'b0, switches_q};
            gpio_buttons_off:    rsp.hrdata = {27'b0, buttons_q};
            default:             rsp.hrdata = '0;
        endcase
    end

    assign rsp.hready = 1'b1;
    assign rsp.hresp  = 1'b0;

endmodule

// ==== source/mfp_ahb_ram.sv ====
module mfp_ahb_ram import mfp_ahb_pkg::*; #(
    parameter int ram_addr_width = 10
) (
    input  logic     hclk,
    input  logic     rst_n,
    input  ahb_req_t req,
    input  logic     hsel,
    input  logic     hready,
    output ahb_rsp_t rsp
);

    logic [31:0]               mem [2**ram_addr_width];
    logic [ram_addr_width-1:0] word_addr;
    logic [2:0]                size;
    logic [1:0]                byte_off;
    logic                      write_pend;
    logic [3:0]                lane_en;

    always_ff @(posedge hclk) begin
        if (!rst_n)
            write_pend <= 1'b0;
        else if (hready)
            write_pend <= hsel && ahb_active(req.htrans) && req.hwrite;
    end

    // address phase payload
    always_ff @(posedge hclk) begin
        if (hready && hsel) begin
            word_addr <= req.haddr[ram_addr_width+1:2];
            size      <= req.hsize;
            byte_off  <= req.haddr[1:0];
        end
    end

    // little-endian lane select
    always_comb begin
        case (size)
            hsize_byte: lane_en = 4'b0001 << byte_off;
            hsize_half: lane_en = byte_off[1] ? 4'b1100 : 4'b0011;
            hsize_word: lane_en = 4'b1111;
            default:    lane_en = 4'b0000;
        endcase
    end

    always_ff @(posedge hclk) begin
        if (write_pend && hready) begin
            for (int i = 0; i < 4; i++) begin
                if (lane_en[i])
                    mem[word_addr][8*i +: 8] <= req.hwdata[8*i +: 8];
            end
        end
    end

    // whole word back, master extracts its lanes
    assign rsp.hrdata = mem[word_addr];
    assign rsp.hready = 1'b1;
    assign rsp.hresp  = 1'b0;

endmodule

// ==== source/mfp_ahb_decoder.sv ====
module mfp_ahb_decoder import mfp_ahb_pkg::*; (
    input  logic        hclk,
    input  logic        rst_n,
    input  ahb_req_t    req,
    output logic        hsel_ram,
    output logic        hsel_gpio,
    output logic        hsel_uart,
    input  ahb_rsp_t    ram_rsp,
    input  ahb_rsp_t    gpio_rsp,
    input  ahb_rsp_t    uart_rsp,
    output logic [31:0] hrdata,
    output logic        hready,
    output logic        hresp
);

    typedef enum logic {
        err_idle,
        err_last
    } err_state_t;

    slave_sel_t addr_sel;
    slave_sel_t data_sel;
    logic       data_active;
    logic       err_start;
    err_state_t err_state;
    ahb_rsp_t   rsp;

    assign hsel_ram  = (req.haddr & ram_region_mask)  == ram_base;
    assign hsel_gpio = (req.haddr & gpio_region_mask) == gpio_base;
    assign hsel_uart = (req.haddr & uart_region_mask) == uart_base;

    always_comb begin
        if (hsel_ram)
            addr_sel = sel_ram;
        else if (hsel_gpio)
            addr_sel = sel_gpio;
        else if (hsel_uart)
            addr_sel = sel_uart;
        else
            addr_sel = sel_none;
    end

    // data phase owner, only moves when the bus is ready
    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            data_sel    <= sel_none;
            data_active <= 1'b0;
        end else if (hready) begin
            data_active <= ahb_active(req.htrans);
            data_sel    <= ahb_active(req.htrans) ? addr_sel : sel_none;
        end
    end

    // unmapped transfer waiting for its first error cycle
    assign err_start = data_active && data_sel == sel_none && err_state == err_idle;

    always_ff @(posedge hclk) begin
        if (!rst_n)
            err_state <= err_idle;
        else if (err_state == err_last)
            err_state <= err_idle;
        else if (err_start)
            err_state <= err_last;
    end

    always_comb begin
        rsp = '{hrdata: '0, hready: 1'b1, hresp: 1'b0};
        case (data_sel)
            sel_ram:  rsp = ram_rsp;
            sel_gpio: rsp = gpio_rsp;
            sel_uart: rsp = uart_rsp;
            default: begin
                if (err_state == err_last) begin
                    rsp.hresp = 1'b1;
                end else if (err_start) begin
                    rsp.hready = 1'b0;
                    rsp.hresp  = 1'b1;
                end
            end
        endcase
    end

    assign hrdata = rsp.hrdata;
    assign hready = rsp.hready;
    assign hresp  = rsp.hresp;

endmodule

// ==== source/mfp_ahb_pkg.sv ====
package mfp_ahb_pkg;

`include "mfp_memory_map.svh"

    // transfer types, busy is not used by this matrix
    localparam logic [1:0] htrans_idle   = 2'b00;
    localparam logic [1:0] htrans_nonseq = 2'b10;
    localparam logic [1:0] htrans_seq    = 2'b11;

    localparam logic [2:0] hsize_byte = 3'b000;
    localparam logic [2:0] hsize_half = 3'b001;
    localparam logic [2:0] hsize_word = 3'b010;

    // address phase, hwdata belongs to the following data phase
    typedef struct packed {
        logic [31:0] haddr;
        logic        hwrite;
        logic [2:0]  hsize;
        logic [1:0]  htrans;
        logic [31:0] hwdata;
    } ahb_req_t;

    typedef struct packed {
        logic [31:0] hrdata;
        logic        hready;
        logic        hresp;
    } ahb_rsp_t;

    typedef enum logic [1:0] {
        sel_none,
        sel_ram,
        sel_gpio,
        sel_uart
    } slave_sel_t;

    function automatic logic ahb_active(input logic [1:0] htrans);
        return htrans == htrans_nonseq || htrans == htrans_seq;
    endfunction

endpackage

// ==== include/mfp_memory_map.svh ====
`ifndef MFP_MEMORY_MAP_SVH
`define MFP_MEMORY_MAP_SVH

// region bases and the address bits that pick a region
localparam logic [31:0] ram_base          = 32'h0000_0000;
localparam logic [31:0] ram_region_mask   = 32'hFFF0_0000;
localparam logic [31:0] gpio_base         = 32'h1F80_0000;
localparam logic [31:0] gpio_region_mask  = 32'hFFFF_0000;
localparam logic [31:0] uart_base         = 32'h1F90_0000;
localparam logic [31:0] uart_region_mask  = 32'hFFFF_0000;

// register offsets inside a region
localparam logic [3:0] gpio_red_leds_off   = 4'h0;
localparam logic [3:0] gpio_green_leds_off = 4'h4;
localparam logic [3:0] gpio_switches_off   = 4'h8;
localparam logic [3:0] gpio_buttons_off    = 4'hC;
localparam logic [3:0] uart_txdata_off     = 4'h0;
localparam logic [3:0] uart_status_off     = 4'h4;
`endif
